//--- cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    // ####################
    // datapath widths
    // ####################

    // register width, one word.
    localparam int XLEN = 32;

    // double word: divider rem/quot register and full product.
    localparam int DXLEN = 2 * XLEN;

    // iteration counter, top bit set after XLEN steps.
    localparam int ITER_CNT_W = 6;

endpackage

//--- muldiv_op_pkg.sv
package muldiv_op_pkg;

    // funct3 field width.
    localparam int OP_W = 3;

    // ####################
    // M extension funct3
    // ####################

    localparam logic [OP_W-1:0] MULDIV_MUL    = 3'd0;
    localparam logic [OP_W-1:0] MULDIV_MULH   = 3'd1;
    localparam logic [OP_W-1:0] MULDIV_MULHSU = 3'd2;
    localparam logic [OP_W-1:0] MULDIV_MULHU  = 3'd3;
    localparam logic [OP_W-1:0] MULDIV_DIV    = 3'd4;
    localparam logic [OP_W-1:0] MULDIV_DIVU   = 3'd5;
    localparam logic [OP_W-1:0] MULDIV_REM    = 3'd6;
    localparam logic [OP_W-1:0] MULDIV_REMU   = 3'd7;

    // set for the divide class.
    localparam int OP_DIV_BIT = 2;

endpackage

//--- muldiv_operand.sv
`timescale 1ns/1ps

module muldiv_operand (
    input  logic [muldiv_op_pkg::OP_W-1:0] op_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]   op1_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]   op2_i,
    output logic                           op1_neg_o,
    output logic                           op2_neg_o,
    output logic [cpu_cfg_pkg::XLEN-1:0]   op1_mag_o,
    output logic [cpu_cfg_pkg::XLEN-1:0]   op2_mag_o
);
    import cpu_cfg_pkg::*;
    import muldiv_op_pkg::*;

    logic op1_signed;
    logic op2_signed;

    // which operands are read as two's complement.
    always_comb begin
        op1_signed = 1'b0;
        op2_signed = 1'b0;
        case (op_i)
            MULDIV_MULH,
            MULDIV_DIV,
            MULDIV_REM: begin
                op1_signed = 1'b1;
                op2_signed = 1'b1;
            end
            MULDIV_MULHSU: begin
                op1_signed = 1'b1; // op2 stays unsigned.
            end
            default: begin
                // MUL low word is sign agnostic.
                op1_signed = 1'b0;
                op2_signed = 1'b0;
            end
        endcase
    end

    assign op1_neg_o = op1_signed & op1_i[XLEN-1];
    assign op2_neg_o = op2_signed & op2_i[XLEN-1];

    // magnitudes for the unsigned cores.
    assign op1_mag_o = op1_neg_o ? -op1_i : op1_i;
    assign op2_mag_o = op2_neg_o ? -op2_i : op2_i;

endmodule

//--- div_core.sv
`timescale 1ns/1ps

module div_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic                         cancel_i,
    input  logic                         op1_neg_i,
    input  logic                         op2_neg_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0] dividend_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0] divisor_i,
    output logic                         stop_o,
    output logic [cpu_cfg_pkg::XLEN-1:0] quot_o,
    output logic [cpu_cfg_pkg::XLEN-1:0] rem_o
);
    import cpu_cfg_pkg::*;

    logic                  run;
    logic [ITER_CNT_W-1:0] cnt;
    logic                  div_zero;
    logic                  div_zero_r;
    logic                  op1_neg_r;
    logic                  op2_neg_r;
    logic [XLEN-1:0]       divisor_r;
    logic [DXLEN-1:0]      rem_quot;   // remainder high, quotient low.
    logic [XLEN:0]         sub_op1;
    logic [XLEN:0]         sub_res;
    logic [XLEN-1:0]       sub_nxt;
    logic [XLEN-1:0]       quot_mag;
    logic [XLEN-1:0]       rem_mag;

    assign div_zero = ~|divisor_i;

    // ####################
    // iteration control
    // ####################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (stop_o || cancel_i) begin
            run <= 1'b0;
        end else if (start_i) begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cancel_i) begin
            cnt <= '0;
        end else if (start_i) begin
            // zero divisor skips straight to the last count.
            cnt <= div_zero ? {1'b1, {(ITER_CNT_W-1){1'b0}}} : '0;
        end else if (run && !stop_o) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    assign stop_o = run & cnt[ITER_CNT_W-1];

    // ####################
    // restoring datapath
    // ####################

    assign sub_op1 = rem_quot[DXLEN-1:XLEN-1];
    assign sub_res = sub_op1 - {1'b0, divisor_r};
    assign sub_nxt = sub_res[XLEN] ? sub_op1[XLEN-1:0] : sub_res[XLEN-1:0]; // restore on borrow.

    always_ff @(posedge clk) begin
        if (start_i) begin
            divisor_r  <= divisor_i;
            op1_neg_r  <= op1_neg_i;
            op2_neg_r  <= op2_neg_i;
            div_zero_r <= div_zero;
            rem_quot   <= div_zero ? {dividend_i, {XLEN{1'b1}}} : {{XLEN{1'b0}}, dividend_i};
        end else if (run && !stop_o && !cancel_i) begin
            rem_quot <= {sub_nxt, rem_quot[XLEN-2:0], ~sub_res[XLEN]};
        end
    end

    assign quot_mag = rem_quot[XLEN-1:0];
    assign rem_mag  = rem_quot[DXLEN-1:XLEN];

    // sign fixup.
    assign quot_o = ((op1_neg_r ^ op2_neg_r) && !div_zero_r) ? -quot_mag : quot_mag;
    assign rem_o  = op1_neg_r ? -rem_mag : rem_mag; // follows the dividend.

endmodule

//--- mul_core.sv
`timescale 1ns/1ps

module mul_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic                          cancel_i,
    input  logic                          op1_neg_i,
    input  logic                          op2_neg_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]  mcand_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]  mplier_i,
    output logic                          stop_o,
    output logic [cpu_cfg_pkg::DXLEN-1:0] prod_o
);
    import cpu_cfg_pkg::*;

    logic                  run;
    logic [ITER_CNT_W-1:0] cnt;
    logic                  neg_r;
    logic [XLEN-1:0]       mcand_r;
    logic [DXLEN-1:0]      acc;     // partial product high, multiplier low.
    logic [XLEN:0]         sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (stop_o || cancel_i) begin
            run <= 1'b0;
        end else if (start_i) begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (run && !stop_o && !cancel_i) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0; // start also lands here.
        end
    end

    assign stop_o = run & cnt[ITER_CNT_W-1];

    // ####################
    // shift-add step
    // ####################

    assign sum = {1'b0, acc[DXLEN-1:XLEN]} + {1'b0, (acc[0] ? mcand_r : {XLEN{1'b0}})};

    always_ff @(posedge clk) begin
        if (start_i) begin
            mcand_r <= mcand_i;
            neg_r   <= op1_neg_i ^ op2_neg_i;
            acc     <= {{XLEN{1'b0}}, mplier_i};
        end else if (run && !stop_o && !cancel_i) begin
            acc <= {sum, acc[XLEN-1:1]}; // carry shifts in at the top.
        end
    end

    assign prod_o = neg_r ? -acc : acc;

endmodule

//--- muldiv_ctrl.sv
`timescale 1ns/1ps

module muldiv_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid_i,
    input  logic                          flush_i,
    input  logic [muldiv_op_pkg::OP_W-1:0] op_i,
    input  logic                          div_stop_i,
    input  logic                          mul_stop_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]  quot_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]  rem_i,
    input  logic [cpu_cfg_pkg::DXLEN-1:0] prod_i,
    output logic                          div_start_o,
    output logic                          mul_start_o,
    output logic                          busy_o,
    output logic                          done_o,
    output logic [cpu_cfg_pkg::XLEN-1:0]  result_o
);
    import cpu_cfg_pkg::*;
    import muldiv_op_pkg::*;

    logic            accept;
    logic            finish;
    logic            core_stop;
    logic [OP_W-1:0] op_r;
    logic [XLEN-1:0] res_sel;

    assign accept      = req_valid_i & ~busy_o & ~flush_i; // flush wins over a new request.
    assign div_start_o = accept & op_i[OP_DIV_BIT];
    assign mul_start_o = accept & ~op_i[OP_DIV_BIT];

    assign core_stop = op_r[OP_DIV_BIT] ? div_stop_i : mul_stop_i;
    assign finish    = busy_o & core_stop & ~flush_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_r <= op_i;
        end
    end

    // result word by funct3.
    always_comb begin
        case (op_r)
            MULDIV_MUL:    res_sel = prod_i[XLEN-1:0];
            MULDIV_MULH,
            MULDIV_MULHSU,
            MULDIV_MULHU:  res_sel = prod_i[DXLEN-1:XLEN];
            MULDIV_DIV,
            MULDIV_DIVU:   res_sel = quot_i;
            default:       res_sel = rem_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= finish;
            if (flush_i || finish) begin
                busy_o <= 1'b0;
            end else if (accept) begin
                busy_o <= 1'b1;
            end
            if (finish) begin
                result_o <= res_sel;
            end
        end
    end

endmodule

//--- muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_valid_i,
    input  logic                           flush_i,
    input  logic [muldiv_op_pkg::OP_W-1:0] req_op_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]   req_op1_i,
    input  logic [cpu_cfg_pkg::XLEN-1:0]   req_op2_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [cpu_cfg_pkg::XLEN-1:0]   result_o
);
    import cpu_cfg_pkg::*;

    logic             op1_neg;
    logic             op2_neg;
    logic [XLEN-1:0]  op1_mag;
    logic [XLEN-1:0]  op2_mag;
    logic             div_start;
    logic             mul_start;
    logic             div_stop;
    logic             mul_stop;
    logic [XLEN-1:0]  quot;
    logic [XLEN-1:0]  rem;
    logic [DXLEN-1:0] prod;

    muldiv_operand muldiv_operand_i (
        .op_i      (req_op_i),
        .op1_i     (req_op1_i),
        .op2_i     (req_op2_i),
        .op1_neg_o (op1_neg),
        .op2_neg_o (op2_neg),
        .op1_mag_o (op1_mag),
        .op2_mag_o (op2_mag)
    );

    div_core div_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start),
        .cancel_i   (flush_i),
        .op1_neg_i  (op1_neg),
        .op2_neg_i  (op2_neg),
        .dividend_i (op1_mag),
        .divisor_i  (op2_mag),
        .stop_o     (div_stop),
        .quot_o     (quot),
        .rem_o      (rem)
    );

    mul_core mul_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mul_start),
        .cancel_i  (flush_i),
        .op1_neg_i (op1_neg),
        .op2_neg_i (op2_neg),
        .mcand_i   (op1_mag),
        .mplier_i  (op2_mag),
        .stop_o    (mul_stop),
        .prod_o    (prod)
    );

    muldiv_ctrl muldiv_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .flush_i     (flush_i),
        .op_i        (req_op_i),
        .div_stop_i  (div_stop),
        .mul_stop_i  (mul_stop),
        .quot_i      (quot),
        .rem_i       (rem),
        .prod_i      (prod),
        .div_start_o (div_start),
        .mul_start_o (mul_start),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .result_o    (result_o)
    );

endmodule

//--- muldiv_chk.sv
`timescale 1ns/1ps

module muldiv_chk (
    input logic clk,
    input logic rst_n,
    input logic req_valid_i,
    input logic flush_i,
    input logic busy_i,
    input logic done_i
);
    logic flushed; // set by a flush until the next accepted request.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flushed <= 1'b0;
        end else if (flush_i) begin
            flushed <= 1'b1;
        end else if (req_valid_i && !busy_i) begin
            flushed <= 1'b0;
        end
    end

    // ####################
    // protocol
    // ####################

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else $error("done_o held for more than one cycle");

    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> $past(busy_i))
        else $error("done_o without busy_o in the cycle before");

    flush_clears_busy: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> !busy_i)
        else $error("busy_o still high after flush");

    no_done_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flushed |-> !done_i)
        else $error("done_o after flush with no new request");

endmodule

bind muldiv_unit muldiv_chk muldiv_chk_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .flush_i     (flush_i),
    .busy_i      (busy_o),
    .done_i      (done_o)
);

//--- tb_muldiv_unit.sv
`timescale 1ns/1ps

module tb_muldiv_unit;
    import cpu_cfg_pkg::*;

    localparam int OPW       = muldiv_op_pkg::OP_W;
    localparam int SEED      = 77700;
    localparam int N_RAND    = 300;
    localparam int N_ZERO    = 8;
    localparam int N_FLUSH   = 20;
    localparam int N_BUSY    = 10;
    // flush and busy tests cost about three operations each.
    localparam int TOTAL_OPS = 2 * N_RAND + 4 * N_ZERO + 8 * 25 + 3 * N_FLUSH + 3 * N_BUSY;
    localparam int MAX_CYCLES = TOTAL_OPS * 40 + 16 + 200;

    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] CORNER [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                              32'h8000_0000, 32'h7fff_ffff};

    logic            clk;
    logic            rst_n;
    logic            req_valid;
    logic            flush;
    logic [OPW-1:0]  req_op;
    logic [XLEN-1:0] req_op1;
    logic [XLEN-1:0] req_op2;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] result;
    int              checks;
    int              errors;
    int              test_err;
    int              cycles;

    muldiv_unit muldiv_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid),
        .flush_i     (flush),
        .req_op_i    (req_op),
        .req_op1_i   (req_op1),
        .req_op2_i   (req_op2),
        .busy_o      (busy),
        .done_o      (done),
        .result_o    (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ####################
    // reference model
    // ####################

    function automatic logic [XLEN-1:0] model_result(logic [OPW-1:0] op, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic signed [DXLEN-1:0] sa;
        logic signed [DXLEN-1:0] sb;
        logic [DXLEN-1:0]        ua;
        logic [DXLEN-1:0]        ub;
        logic [DXLEN-1:0]        prod;
        logic                    is_rem;
        logic                    is_signed_div;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        is_rem = (op == muldiv_op_pkg::MULDIV_REM) || (op == muldiv_op_pkg::MULDIV_REMU);
        is_signed_div = (op == muldiv_op_pkg::MULDIV_DIV) || (op == muldiv_op_pkg::MULDIV_REM);
        if (op >= muldiv_op_pkg::MULDIV_DIV && b == '0) begin
            return is_rem ? a : '1; // riscv divide by zero.
        end
        if (is_signed_div && a == MIN_INT && b == '1) begin
            return is_rem ? '0 : MIN_INT; // overflow case.
        end
        case (op)
            muldiv_op_pkg::MULDIV_MULH:   prod = sa * sb;
            muldiv_op_pkg::MULDIV_MULHSU: prod = sa * $signed(ub);
            muldiv_op_pkg::MULDIV_DIV:    prod = sa / sb;
            muldiv_op_pkg::MULDIV_DIVU:   prod = ua / ub;
            muldiv_op_pkg::MULDIV_REM:    prod = sa % sb;
            muldiv_op_pkg::MULDIV_REMU:   prod = ua % ub;
            default:                      prod = ua * ub;
        endcase
        if (op == muldiv_op_pkg::MULDIV_MUL || op >= muldiv_op_pkg::MULDIV_DIV) begin
            return prod[XLEN-1:0];
        end
        return prod[DXLEN-1:XLEN];
    endfunction

    // mixes operand sizes so the divider sees small quotients too.
    function automatic logic [XLEN-1:0] rand_operand();
        logic [XLEN-1:0] v;
        v = $urandom() >> $urandom_range(0, XLEN - 1);
        if ($urandom_range(0, 1) == 1) begin
            v = -v;
        end
        return v;
    endfunction

    task automatic check_value(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic send_req(logic [OPW-1:0] op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        @(negedge clk);
        req_valid = 1'b1;
        req_op    = op;
        req_op1   = a;
        req_op2   = b;
        @(negedge clk);
        req_valid = 1'b0;
        req_op1   = $urandom(); // operands are only valid in the strobe cycle.
        req_op2   = $urandom();
    endtask

    task automatic run_op(string name, logic [OPW-1:0] op, logic [XLEN-1:0] a,
                          logic [XLEN-1:0] b);
        string tag;
        tag = $sformatf("%s funct3=%0d op1=%h op2=%h", name, op, a, b);
        send_req(op, a, b);
        while (!done) begin
            @(negedge clk);
        end
        check_value(tag, model_result(op, a, b), result);
    endtask

    task automatic end_test(string name);
        $display("test %s finished, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // ####################
    // stimulus
    // ####################

    initial begin
        logic [OPW-1:0]  op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] got;
        int              n_done;
        void'($urandom(SEED));
        req_valid = 1'b0;
        flush     = 1'b0;
        req_op    = '0;
        req_op1   = '0;
        req_op2   = '0;
        rst_n     = 1'b0;
        checks    = 0;
        errors    = 0;
        test_err  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_RAND; i++) begin
            op = OPW'($urandom_range(0, 3));
            run_op("mul_random", op, $urandom(), rand_operand());
        end
        end_test("mul_random");

        for (int i = 0; i < N_RAND; i++) begin
            op = OPW'($urandom_range(4, 7));
            run_op("div_random", op, $urandom(), rand_operand());
        end
        end_test("div_random");

        for (int i = 0; i < 4 * N_ZERO; i++) begin
            run_op("div_zero", OPW'(4 + i % 4), $urandom(), '0);
        end
        end_test("div_zero");

        for (int o = 0; o < 8; o++) begin
            foreach (CORNER[i]) begin
                foreach (CORNER[j]) begin
                    run_op("corner", OPW'(o), CORNER[i], CORNER[j]);
                end
            end
        end
        end_test("corner");

        for (int i = 0; i < N_FLUSH; i++) begin
            op = OPW'($urandom_range(0, 7));
            send_req(op, $urandom(), rand_operand() | 32'd1);
            repeat ($urandom_range(0, 28)) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            checks++;
            if (busy) begin
                errors++;
                $display("flush test %0d: busy_o still high after the flush", i);
            end
            n_done = 0;
            repeat (45) begin
                if (done) begin
                    n_done++;
                end
                @(negedge clk);
            end
            checks++;
            if (n_done != 0) begin
                errors++;
                $display("flush test %0d: done_o pulsed after the flush", i);
            end
            run_op("flush_recover", OPW'($urandom_range(0, 7)), $urandom(), rand_operand());
        end
        end_test("flush");

        for (int i = 0; i < N_BUSY; i++) begin
            op = OPW'($urandom_range(0, 7));
            a  = $urandom();
            b  = rand_operand() | 32'd1;
            send_req(op, a, b);
            repeat ($urandom_range(0, 28)) @(negedge clk);
            checks++;
            if (!busy) begin
                errors++;
                $display("busy test %0d: busy_o low before the second strobe", i);
            end
            req_valid = 1'b1; // second strobe, must be dropped.
            req_op    = ~op;
            req_op1   = $urandom();
            req_op2   = $urandom();
            @(negedge clk);
            req_valid = 1'b0;
            n_done = 0;
            got    = '0;
            repeat (60) begin
                if (done) begin
                    n_done++;
                    got = result;
                end
                @(negedge clk);
            end
            checks++;
            if (n_done != 1) begin
                errors++;
                $display("busy test %0d: expected one done_o pulse, saw %0d", i, n_done);
            end
            check_value($sformatf("busy_ignore %0d", i), model_result(op, a, b), got);
        end
        end_test("busy_ignore");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // run limit.
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no end of run after %0d cycles", cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- compile.f
cpu_cfg_pkg.sv
muldiv_op_pkg.sv
muldiv_operand.sv
div_core.sv
mul_core.sv
muldiv_ctrl.sv
muldiv_unit.sv
muldiv_chk.sv
tb_muldiv_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the muldiv testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_muldiv_unit -o sim_muldiv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_muldiv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "simulation did not report success"
exit 1
